// ==== design/rename_pkg.sv ====
package rename_pkg;

  // bundle and register file shape
  localparam int BUNDLE_WIDTH    = 2;
  localparam int NUM_ARCH_REGS   = 32;
  localparam int NZCV_INDEX      = NUM_ARCH_REGS; // flags sit just above the gprs
  localparam int NUM_PHYS_REGS   = 128;
  localparam int TAGS_PER_BUNDLE = 3 * BUNDLE_WIDTH; // dst, imm, flags per slot
  localparam int FREE_INIT_COUNT = NUM_PHYS_REGS - NUM_ARCH_REGS - 1;
  localparam int INSN_BYTES      = 4;

  typedef logic [5:0]  arch_reg_t;  // 0..31 gprs, 32 is nzcv
  typedef logic [6:0]  phys_tag_t;
  typedef logic [63:0] addr_t;
  typedef logic [15:0] imm_t;
  typedef logic [63:0] reg_data_t;

  // free list bookkeeping
  typedef logic [$clog2(TAGS_PER_BUNDLE+1)-1:0] take_count_t;
  typedef logic [$clog2(NUM_PHYS_REGS)-1:0]     free_ptr_t;
  typedef logic [$clog2(NUM_PHYS_REGS):0]       free_count_t;

  typedef enum logic [3:0] {
    UOP_NOP   = 4'h0,
    UOP_ADD   = 4'h1,
    UOP_SUB   = 4'h2,
    UOP_AND   = 4'h3,
    UOP_ADDI  = 4'h4,
    UOP_SUBI  = 4'h5,
    UOP_BL    = 4'h6,
    UOP_BCOND = 4'h7,
    UOP_HLT   = 4'h8
  } uop_op_t;

  // one entry of the instruction queue
  typedef struct packed {
    addr_t     pc;
    uop_op_t   op;
    logic      valb_sel;      // set when operand b is a register
    arch_reg_t dst;
    arch_reg_t src1;
    arch_reg_t src2;
    imm_t      imm;
    logic      predict_taken;
    addr_t     branch_target;
  } uop_insn_t;

  typedef struct packed {
    uop_op_t   op;
    addr_t     pc;
    addr_t     next_pc;
    logic      allocates;
    logic      uses_imm;
    arch_reg_t dst;
    arch_reg_t src1;
    arch_reg_t src2;
    imm_t      imm;
  } rename_req_t;

  typedef struct packed {
    addr_t     pc;
    addr_t     next_pc;
    uop_op_t   op;
    phys_tag_t r1_phys;
    phys_tag_t r2_phys;
    phys_tag_t dest_phys;
    phys_tag_t old_dest_phys;  // freed when this uop commits
    phys_tag_t nzcv_phys;
    phys_tag_t old_nzcv_phys;
  } rob_entry_t;

  typedef struct packed {
    logic      en;
    phys_tag_t index;
    reg_data_t data;
  } regfile_wr_t;

  typedef phys_tag_t [TAGS_PER_BUNDLE-1:0] alloc_tags_t;

endpackage

// ==== design/uop_decode.sv ====
`timescale 1ns/1ps

module uop_decode (
  input  rename_pkg::uop_insn_t   [rename_pkg::BUNDLE_WIDTH-1:0] instr,
  output rename_pkg::rename_req_t [rename_pkg::BUNDLE_WIDTH-1:0] reqs
);

  logic [rename_pkg::BUNDLE_WIDTH-1:0] allocates;
  logic [rename_pkg::BUNDLE_WIDTH-1:0] is_rr;
  logic [rename_pkg::BUNDLE_WIDTH-1:0] is_ri;
  logic [rename_pkg::BUNDLE_WIDTH-1:0] taken;

  // slot classification
  always_comb begin
    for (int i = 0; i < rename_pkg::BUNDLE_WIDTH; i++) begin
      allocates[i] = (instr[i].op != rename_pkg::UOP_NOP) &&
                     (instr[i].op != rename_pkg::UOP_HLT); // bubbles and halt take no tags
      is_rr[i]     = allocates[i] && instr[i].valb_sel;
      is_ri[i]     = allocates[i] && !instr[i].valb_sel;
      taken[i]     = instr[i].predict_taken &&
                     ((instr[i].op == rename_pkg::UOP_BL) ||
                      (instr[i].op == rename_pkg::UOP_BCOND));
    end
  end

  always_comb begin
    for (int i = 0; i < rename_pkg::BUNDLE_WIDTH; i++) begin
      reqs[i].op        = instr[i].op;
      reqs[i].pc        = instr[i].pc;
      reqs[i].allocates = allocates[i];
      reqs[i].uses_imm  = is_ri[i];

      // non-allocating slots carry zeroed register fields
      reqs[i].dst  = allocates[i] ? instr[i].dst : '0;
      reqs[i].src1 = allocates[i] ? instr[i].src1 : '0;
      reqs[i].src2 = is_rr[i] ? instr[i].src2 : '0;
      reqs[i].imm  = is_ri[i] ? instr[i].imm : '0;

      if (taken[i]) begin
        reqs[i].next_pc = instr[i].branch_target;
      end else begin
        reqs[i].next_pc = instr[i].pc + rename_pkg::addr_t'(rename_pkg::INSN_BYTES);
      end
    end
  end

endmodule

// ==== design/free_reg_list.sv ====
`timescale 1ns/1ps

module free_reg_list (
  input  logic                                                 clk,
  input  logic                                                 rst_N_in,
  input  rename_pkg::take_count_t                              take_count,
  input  logic                  [rename_pkg::BUNDLE_WIDTH-1:0] rel_valid,
  input  rename_pkg::phys_tag_t [rename_pkg::BUNDLE_WIDTH-1:0] rel_tag,
  output rename_pkg::alloc_tags_t                              head_tags,
  output logic                                                 has_bundle
);

  rename_pkg::phys_tag_t   fifo_mem [rename_pkg::NUM_PHYS_REGS];
  rename_pkg::free_ptr_t   head_q;
  rename_pkg::free_ptr_t   tail_q;
  rename_pkg::free_count_t count_q;
  rename_pkg::free_count_t push_count;

  // pointers are log2 of the depth wide, so they wrap on their own
  always_comb begin
    for (int k = 0; k < rename_pkg::TAGS_PER_BUNDLE; k++) begin
      head_tags[k] = fifo_mem[head_q + rename_pkg::free_ptr_t'(k)];
    end
  end

  assign has_bundle = count_q >= rename_pkg::free_count_t'(rename_pkg::TAGS_PER_BUNDLE);

  always_comb begin
    push_count = '0;
    for (int i = 0; i < rename_pkg::BUNDLE_WIDTH; i++) begin
      push_count = push_count + rename_pkg::free_count_t'(rel_valid[i]);
    end
  end

  always_ff @(posedge clk) begin
    rename_pkg::free_ptr_t wr_ptr;
    if (!rst_N_in) begin
      // every tag above the identity mapping starts out free
      for (int i = 0; i < rename_pkg::FREE_INIT_COUNT; i++) begin
        fifo_mem[i] <= rename_pkg::phys_tag_t'(rename_pkg::NUM_ARCH_REGS + 1 + i);
      end
      head_q  <= '0;
      tail_q  <= rename_pkg::free_ptr_t'(rename_pkg::FREE_INIT_COUNT);
      count_q <= rename_pkg::free_count_t'(rename_pkg::FREE_INIT_COUNT);
    end else begin
      wr_ptr = tail_q;
      for (int i = 0; i < rename_pkg::BUNDLE_WIDTH; i++) begin
        if (rel_valid[i]) begin  // slot 0 lands first
          fifo_mem[wr_ptr] <= rel_tag[i];
          wr_ptr = wr_ptr + rename_pkg::free_ptr_t'(1);
        end
      end
      head_q  <= head_q + rename_pkg::free_ptr_t'(take_count);
      tail_q  <= wr_ptr;
      count_q <= count_q + push_count - rename_pkg::free_count_t'(take_count);
    end
  end

endmodule

// ==== design/rat.sv ====
`timescale 1ns/1ps

module rat (
  input  logic                                                    clk,
  input  logic                                                    rst_N_in,
  input  rename_pkg::rename_req_t [rename_pkg::BUNDLE_WIDTH-1:0]  reqs,
  input  logic                                                    q_valid,
  input  logic                                                    rob_ready,
  input  rename_pkg::alloc_tags_t                                 head_tags,
  input  logic                                                    has_bundle,
  output logic                                                    q_ready,
  output rename_pkg::take_count_t                                 take_count,
  output logic                                                    accept,
  output rename_pkg::rob_entry_t  [rename_pkg::BUNDLE_WIDTH-1:0]  entries,
  output rename_pkg::regfile_wr_t [rename_pkg::BUNDLE_WIDTH-1:0]  imm_wr
);

  rename_pkg::phys_tag_t [rename_pkg::NZCV_INDEX:0] map_q; // top entry is nzcv
  rename_pkg::phys_tag_t [rename_pkg::NZCV_INDEX:0] map_d; // map after the whole bundle
  rename_pkg::take_count_t used;

  // only move when a full bundle worth of tags is on hand
  assign q_ready    = rob_ready && has_bundle;
  assign accept     = q_valid && q_ready;
  assign take_count = accept ? used : '0;

  always_comb begin
    rename_pkg::take_count_t pos;
    rename_pkg::phys_tag_t   dtag;
    rename_pkg::phys_tag_t   itag;
    rename_pkg::phys_tag_t   ftag;
    map_d = map_q;
    pos   = '0;
    for (int i = 0; i < rename_pkg::BUNDLE_WIDTH; i++) begin
      dtag = '0;
      itag = '0;
      ftag = '0;

      entries[i]         = '0;
      entries[i].pc      = reqs[i].pc;
      entries[i].next_pc = reqs[i].next_pc;
      entries[i].op      = reqs[i].op;
      imm_wr[i]          = '0;

      if (reqs[i].allocates) begin
        // compact order from the head: dst, imm if any, flags
        dtag = head_tags[pos];
        pos  = pos + rename_pkg::take_count_t'(1);
        if (reqs[i].uses_imm) begin
          itag = head_tags[pos];
          pos  = pos + rename_pkg::take_count_t'(1);
        end
        ftag = head_tags[pos];
        pos  = pos + rename_pkg::take_count_t'(1);

        // map_d already holds earlier slots' writes, which gives the bypass
        entries[i].r1_phys       = map_d[reqs[i].src1];
        entries[i].r2_phys       = reqs[i].uses_imm ? itag : map_d[reqs[i].src2];
        entries[i].dest_phys     = dtag;
        entries[i].old_dest_phys = map_d[reqs[i].dst];
        entries[i].nzcv_phys     = ftag;
        entries[i].old_nzcv_phys = map_d[rename_pkg::NZCV_INDEX];

        imm_wr[i].en    = reqs[i].uses_imm;
        imm_wr[i].index = itag;
        imm_wr[i].data  = rename_pkg::reg_data_t'(reqs[i].imm); // zero unless ri

        map_d[reqs[i].dst]           = dtag;
        map_d[rename_pkg::NZCV_INDEX] = ftag;
      end
    end
    used = pos;
  end

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      for (int r = 0; r <= rename_pkg::NZCV_INDEX; r++) begin
        map_q[r] <= rename_pkg::phys_tag_t'(r); // identity
      end
    end else if (accept) begin
      map_q <= map_d;
    end
  end

endmodule

// ==== design/rob_alloc.sv ====
`timescale 1ns/1ps

module rob_alloc (
  input  logic                                                   clk,
  input  logic                                                   rst_N_in,
  input  logic                                                   accept,
  input  rename_pkg::rob_entry_t  [rename_pkg::BUNDLE_WIDTH-1:0] entries,
  input  rename_pkg::regfile_wr_t [rename_pkg::BUNDLE_WIDTH-1:0] imm_wr,
  output rename_pkg::rob_entry_t  [rename_pkg::BUNDLE_WIDTH-1:0] rob_data,
  output logic                                                   rob_data_valid,
  output rename_pkg::regfile_wr_t [rename_pkg::BUNDLE_WIDTH-1:0] regfile
);

  logic                  [rename_pkg::BUNDLE_WIDTH-1:0] wr_en_q;
  rename_pkg::phys_tag_t [rename_pkg::BUNDLE_WIDTH-1:0] wr_index_q;
  rename_pkg::reg_data_t [rename_pkg::BUNDLE_WIDTH-1:0] wr_data_q;

  // strobes last a single cycle per accepted bundle
  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      rob_data_valid <= 1'b0;
      wr_en_q        <= '0;
    end else begin
      rob_data_valid <= accept;
      for (int i = 0; i < rename_pkg::BUNDLE_WIDTH; i++) begin
        wr_en_q[i] <= accept && imm_wr[i].en;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rob_data <= entries;
      for (int i = 0; i < rename_pkg::BUNDLE_WIDTH; i++) begin
        wr_index_q[i] <= imm_wr[i].index;
        wr_data_q[i]  <= imm_wr[i].data;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < rename_pkg::BUNDLE_WIDTH; i++) begin
      regfile[i].en    = wr_en_q[i];
      regfile[i].index = wr_index_q[i];
      regfile[i].data  = wr_data_q[i];
    end
  end

endmodule

// ==== design/rename_top.sv ====
`timescale 1ns/1ps

module rename_top (
  input  logic                                                   clk,
  input  logic                                                   rst_N_in,
  input  logic                                                   q_valid,
  input  rename_pkg::uop_insn_t   [rename_pkg::BUNDLE_WIDTH-1:0] instr,
  output logic                                                   q_ready,
  input  logic                                                   rob_ready,
  output rename_pkg::rob_entry_t  [rename_pkg::BUNDLE_WIDTH-1:0] rob_data,
  output logic                                                   rob_data_valid,
  output rename_pkg::regfile_wr_t [rename_pkg::BUNDLE_WIDTH-1:0] regfile,
  input  logic                    [rename_pkg::BUNDLE_WIDTH-1:0] rel_valid,
  input  rename_pkg::phys_tag_t   [rename_pkg::BUNDLE_WIDTH-1:0] rel_tag
);

  rename_pkg::rename_req_t [rename_pkg::BUNDLE_WIDTH-1:0] reqs;
  rename_pkg::alloc_tags_t                               head_tags;
  logic                                                  has_bundle;
  rename_pkg::take_count_t                               take_count;
  logic                                                  accept;
  rename_pkg::rob_entry_t  [rename_pkg::BUNDLE_WIDTH-1:0] entries;
  rename_pkg::regfile_wr_t [rename_pkg::BUNDLE_WIDTH-1:0] imm_wr;

  uop_decode decode_inst (
    .instr (instr),
    .reqs  (reqs)
  );

  rat rat_inst (
    .clk        (clk),
    .rst_N_in   (rst_N_in),
    .reqs       (reqs),
    .q_valid    (q_valid),
    .rob_ready  (rob_ready),
    .head_tags  (head_tags),
    .has_bundle (has_bundle),
    .q_ready    (q_ready),
    .take_count (take_count),
    .accept     (accept),
    .entries    (entries),
    .imm_wr     (imm_wr)
  );

  free_reg_list free_list_inst (
    .clk        (clk),
    .rst_N_in   (rst_N_in),
    .take_count (take_count),
    .rel_valid  (rel_valid),
    .rel_tag    (rel_tag),
    .head_tags  (head_tags),
    .has_bundle (has_bundle)
  );

  rob_alloc rob_alloc_inst (
    .clk            (clk),
    .rst_N_in       (rst_N_in),
    .accept         (accept),
    .entries        (entries),
    .imm_wr         (imm_wr),
    .rob_data       (rob_data),
    .rob_data_valid (rob_data_valid),
    .regfile        (regfile)
  );

endmodule

// ==== test/rename_assert.sv ====
`timescale 1ns/1ps

module rename_assert (
  input logic                                                   clk,
  input logic                                                   rst_N_in,
  input logic                                                   q_valid,
  input logic                                                   q_ready,
  input logic                                                   rob_ready,
  input logic                                                   rob_data_valid,
  input rename_pkg::regfile_wr_t [rename_pkg::BUNDLE_WIDTH-1:0] regfile
);

  logic any_wr_en;

  always_comb begin
    any_wr_en = 1'b0;
    for (int i = 0; i < rename_pkg::BUNDLE_WIDTH; i++) begin
      any_wr_en = any_wr_en | regfile[i].en;
    end
  end

  ready_needs_rob: assert property (@(posedge clk) disable iff (!rst_N_in)
    q_ready |-> rob_ready)
    else $error("q_ready high while rob_ready is low");

  valid_after_accept: assert property (@(posedge clk) disable iff (!rst_N_in)
    (q_valid && q_ready) |=> rob_data_valid)
    else $error("rob_data_valid missing one cycle after acceptance");

  valid_only_after_accept: assert property (@(posedge clk) disable iff (!rst_N_in)
    !(q_valid && q_ready) |=> !rob_data_valid)
    else $error("rob_data_valid high without an acceptance");

  wr_needs_valid: assert property (@(posedge clk) disable iff (!rst_N_in)
    any_wr_en |-> rob_data_valid)
    else $error("regfile write enable high without rob_data_valid");

endmodule

bind rename_top rename_assert rename_assert_inst (
  .clk            (clk),
  .rst_N_in       (rst_N_in),
  .q_valid        (q_valid),
  .q_ready        (q_ready),
  .rob_ready      (rob_ready),
  .rob_data_valid (rob_data_valid),
  .regfile        (regfile)
);

// ==== test/rename_tb.sv ====
`timescale 1ns/1ps

module rename_tb;

  localparam int NUM_CYCLES  = 2000;
  localparam int MIN_BUNDLES = 300;
  localparam int STALL_LIMIT = 400;
  localparam int HOLD_START  = 1000; // releases held back so the free list drains
  localparam int HOLD_END    = 1300;

  logic                                                   clk;
  logic                                                   rst_N_in;
  logic                                                   q_valid;
  logic                                                   q_ready;
  logic                                                   rob_ready;
  rename_pkg::uop_insn_t   [rename_pkg::BUNDLE_WIDTH-1:0] instr;
  rename_pkg::rob_entry_t  [rename_pkg::BUNDLE_WIDTH-1:0] rob_data;
  logic                                                   rob_data_valid;
  rename_pkg::regfile_wr_t [rename_pkg::BUNDLE_WIDTH-1:0] regfile;
  logic                    [rename_pkg::BUNDLE_WIDTH-1:0] rel_valid;
  rename_pkg::phys_tag_t   [rename_pkg::BUNDLE_WIDTH-1:0] rel_tag;

  // reference model
  rename_pkg::phys_tag_t   model_map [rename_pkg::NZCV_INDEX+1];
  rename_pkg::phys_tag_t   model_free [$];
  rename_pkg::phys_tag_t   pend_tag [$];  // tags waiting for commit
  int                      pend_due [$];
  rename_pkg::rob_entry_t  exp_rob [rename_pkg::BUNDLE_WIDTH];
  rename_pkg::regfile_wr_t exp_rf [rename_pkg::BUNDLE_WIDTH];
  logic                    exp_valid;
  int                      cyc;
  int                      accepted;
  int                      idle_cycles;

  rename_top rename_top_inst (
    .clk            (clk),
    .rst_N_in       (rst_N_in),
    .q_valid        (q_valid),
    .instr          (instr),
    .q_ready        (q_ready),
    .rob_ready      (rob_ready),
    .rob_data       (rob_data),
    .rob_data_valid (rob_data_valid),
    .regfile        (regfile),
    .rel_valid      (rel_valid),
    .rel_tag        (rel_tag)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s actual=%h expected=%h", name, actual, expected);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  function automatic rename_pkg::uop_insn_t random_insn();
    rename_pkg::uop_insn_t u;
    u.pc            = {$urandom, $urandom};
    u.op            = rename_pkg::uop_op_t'($urandom % 9);
    u.valb_sel      = 1'($urandom);
    u.dst           = rename_pkg::arch_reg_t'($urandom % 32);
    u.src1          = rename_pkg::arch_reg_t'($urandom % 33); // flags readable too
    u.src2          = rename_pkg::arch_reg_t'($urandom % 33);
    u.imm           = rename_pkg::imm_t'($urandom);
    u.predict_taken = 1'($urandom);
    u.branch_target = {$urandom, $urandom};
    return u;
  endfunction

  task automatic queue_release(input rename_pkg::phys_tag_t tag);
    int due;
    due = cyc + 2 + int'($urandom % 6);
    if (pend_due.size() > 0 && due < pend_due[$]) due = pend_due[$]; // keep fifo order
    pend_tag.push_back(tag);
    pend_due.push_back(due);
  endtask

  task automatic drive_inputs();
    q_valid   = ($urandom % 4) != 0;
    rob_ready = ($urandom % 4) != 0; // low about a quarter of the time
    rel_valid = '0;
    rel_tag   = '0;
    for (int s = 0; s < rename_pkg::BUNDLE_WIDTH; s++) begin
      instr[s] = random_insn();
      // a skipped slot 0 leaves slot 1 to release alone
      if (pend_tag.size() > 0 && pend_due[0] <= cyc && ($urandom % 4) != 0 &&
          !(cyc >= HOLD_START && cyc < HOLD_END)) begin
        rel_valid[s] = 1'b1;
        rel_tag[s]   = pend_tag.pop_front();
        void'(pend_due.pop_front());
      end
    end
  endtask

  // expected result of one accepted bundle, tags in compact head order
  task automatic rename_bundle();
    int                    pos;
    logic                  taken;
    rename_pkg::phys_tag_t dtag;
    rename_pkg::phys_tag_t itag;
    rename_pkg::phys_tag_t ftag;
    pos = 0;
    for (int s = 0; s < rename_pkg::BUNDLE_WIDTH; s++) begin
      exp_rob[s]    = '0;
      exp_rf[s]     = '0;
      exp_rob[s].pc = instr[s].pc;
      exp_rob[s].op = instr[s].op;
      taken = instr[s].predict_taken &&
              (instr[s].op == rename_pkg::UOP_BL || instr[s].op == rename_pkg::UOP_BCOND);
      exp_rob[s].next_pc = taken ? instr[s].branch_target : instr[s].pc + 64'd4;
      if (instr[s].op != rename_pkg::UOP_NOP && instr[s].op != rename_pkg::UOP_HLT) begin
        itag = '0;
        dtag = model_free[pos];
        pos++;
        if (!instr[s].valb_sel) begin
          itag = model_free[pos];
          pos++;
        end
        ftag = model_free[pos];
        pos++;
        exp_rob[s].r1_phys       = model_map[instr[s].src1];
        exp_rob[s].r2_phys       = instr[s].valb_sel ? model_map[instr[s].src2] : itag;
        exp_rob[s].dest_phys     = dtag;
        exp_rob[s].old_dest_phys = model_map[instr[s].dst];
        exp_rob[s].nzcv_phys     = ftag;
        exp_rob[s].old_nzcv_phys = model_map[rename_pkg::NZCV_INDEX];
        if (!instr[s].valb_sel) begin
          exp_rf[s].en    = 1'b1;
          exp_rf[s].index = itag;
          exp_rf[s].data  = {48'h0, instr[s].imm};
          queue_release(itag);
        end
        queue_release(exp_rob[s].old_dest_phys);
        queue_release(exp_rob[s].old_nzcv_phys);
        model_map[instr[s].dst]          = dtag;
        model_map[rename_pkg::NZCV_INDEX] = ftag;
      end
    end
    repeat (pos) void'(model_free.pop_front());
  endtask

  task automatic model_step();
    logic exp_ready;
    exp_ready = rob_ready && (model_free.size() >= rename_pkg::TAGS_PER_BUNDLE);
    check_value("q_ready", 64'(q_ready), 64'(exp_ready));
    exp_valid = q_valid && exp_ready;
    if (exp_valid) begin
      rename_bundle();
      accepted++;
      idle_cycles = 0;
    end else begin
      idle_cycles++;
    end
    for (int s = 0; s < rename_pkg::BUNDLE_WIDTH; s++) begin
      if (rel_valid[s]) model_free.push_back(rel_tag[s]); // slot 0 first
    end
    if (idle_cycles > STALL_LIMIT) begin
      abort_run($sformatf("no bundle accepted for %0d cycles", STALL_LIMIT));
    end
  endtask

  task automatic check_outputs();
    check_value("rob_data_valid", 64'(rob_data_valid), 64'(exp_valid));
    for (int s = 0; s < rename_pkg::BUNDLE_WIDTH; s++) begin
      check_value($sformatf("regfile[%0d].en", s), 64'(regfile[s].en),
                  64'(exp_valid && exp_rf[s].en));
      if (exp_valid) begin
        check_value($sformatf("regfile[%0d].index", s), 64'(regfile[s].index),
                    64'(exp_rf[s].index));
        check_value($sformatf("regfile[%0d].data", s), regfile[s].data, exp_rf[s].data);
        check_value($sformatf("rob_data[%0d].pc", s), rob_data[s].pc, exp_rob[s].pc);
        check_value($sformatf("rob_data[%0d].next_pc", s), rob_data[s].next_pc,
                    exp_rob[s].next_pc);
        check_value($sformatf("rob_data[%0d].op", s), 64'(rob_data[s].op), 64'(exp_rob[s].op));
        check_value($sformatf("rob_data[%0d].r1_phys", s), 64'(rob_data[s].r1_phys),
                    64'(exp_rob[s].r1_phys));
        check_value($sformatf("rob_data[%0d].r2_phys", s), 64'(rob_data[s].r2_phys),
                    64'(exp_rob[s].r2_phys));
        check_value($sformatf("rob_data[%0d].dest_phys", s), 64'(rob_data[s].dest_phys),
                    64'(exp_rob[s].dest_phys));
        check_value($sformatf("rob_data[%0d].old_dest_phys", s),
                    64'(rob_data[s].old_dest_phys), 64'(exp_rob[s].old_dest_phys));
        check_value($sformatf("rob_data[%0d].nzcv_phys", s), 64'(rob_data[s].nzcv_phys),
                    64'(exp_rob[s].nzcv_phys));
        check_value($sformatf("rob_data[%0d].old_nzcv_phys", s),
                    64'(rob_data[s].old_nzcv_phys), 64'(exp_rob[s].old_nzcv_phys));
      end
    end
  endtask

  initial begin
    void'($urandom(32'h9bc4_ad79));
    rst_N_in    = 1'b0;
    q_valid     = 1'b0;
    rob_ready   = 1'b0;
    instr       = '0;
    rel_valid   = '0;
    rel_tag     = '0;
    exp_valid   = 1'b0;
    accepted    = 0;
    idle_cycles = 0;
    cyc         = 0;
    for (int r = 0; r <= rename_pkg::NZCV_INDEX; r++) begin
      model_map[r] = rename_pkg::phys_tag_t'(r); // identity after reset
    end
    for (int t = 0; t < rename_pkg::FREE_INIT_COUNT; t++) begin
      model_free.push_back(rename_pkg::phys_tag_t'(rename_pkg::NUM_ARCH_REGS + 1 + t));
    end

    repeat (8) @(posedge clk);
    #2;
    rst_N_in = 1'b1;
    check_outputs(); // outputs come out of reset idle

    for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      drive_inputs();   // 2 ns after the edge
      #1;
      model_step();
      @(posedge clk);
      #1;
      check_outputs();
      #1;
    end

    if (accepted < MIN_BUNDLES) begin
      abort_run($sformatf("only %0d bundles accepted, at least %0d needed",
                          accepted, MIN_BUNDLES));
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
design/rename_pkg.sv
design/uop_decode.sv
design/free_reg_list.sv
design/rat.sv
design/rob_alloc.sv
design/rename_top.sv
test/rename_assert.sv
test/rename_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= === PASS ===

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
